// File: dv/dvs_hssl_props.sv
// handshake and reset properties on the event to packet path top
`timescale 1ns/100ps

module dvs_hssl_props (
  input logic                 pl_clk0_buf_int,
  input logic                 rst_n,
  input logic                 psel,
  input logic                 penable,
  input logic                 pready,
  input dvs_hssl_pkg::evt_t   evt_data,
  input logic                 evt_vld,
  input logic                 evt_rdy,
  input dvs_hssl_pkg::key_t   out_key,
  input dvs_hssl_pkg::route_t out_route,
  input logic                 out_vld,
  input logic                 out_rdy
);
  import dvs_hssl_pkg::*;

  // ----------------------------------------------------------------------
  // valid/ready hold rules
  // ----------------------------------------------------------------------
  // stalled output keeps key and route
  out_hold: assert property (@(posedge pl_clk0_buf_int) disable iff (!rst_n)
    out_vld && !out_rdy |=> out_vld && $stable(out_key) && $stable(out_route))
    else $error("stalled output changed before it was taken");

  // stalled event keeps its data
  evt_hold: assert property (@(posedge pl_clk0_buf_int) disable iff (!rst_n)
    evt_vld && !evt_rdy |=> evt_vld && $stable(evt_data))
    else $error("stalled event changed before it was taken");

  // no wait states on apb
  apb_ready: assert property (@(posedge pl_clk0_buf_int) disable iff (!rst_n)
    psel && penable |-> pready)
    else $error("pready low in an apb access phase");

  // output register cleared by reset
  reset_out: assert property (@(posedge pl_clk0_buf_int) !rst_n |=> !out_vld)
    else $error("out_vld high in the cycle after reset");

endmodule

bind dvs_hssl_top dvs_hssl_props u_props (.*);

// File: dv/dvs_hssl_tb.sv
// testbench for the sensor event to packet path, apb setup plus event traffic
`timescale 1ns/100ps
`include "dvs_hssl_consts.svh"

module dvs_hssl_tb;
  import dvs_hssl_pkg::*;

  localparam int N_MATCH_EVENTS = 200;
  localparam int N_DROP_EVENTS  = 200;
  localparam int N_STOP_EVENTS  = 60;
  localparam int N_EVENTS       = N_MATCH_EVENTS + N_DROP_EVENTS + N_STOP_EVENTS;
  localparam int CYCLE_LIMIT    = 20 * N_EVENTS + 2000;
  localparam int STOP_HOLD      = 40;
  localparam int SEED           = 95143;
  localparam apb_addr_t BAD_ADDR [6] = '{8'h08, 8'h0C, 8'h12, 8'h30, 8'hA4, 8'hFC};

  logic      pl_clk0_buf_int;
  logic      rst_n;
  logic      psel;
  logic      penable;
  logic      pwrite;
  apb_addr_t paddr;
  key_t      pwdata;
  key_t      prdata;
  logic      pready;
  logic      pslverr;
  evt_t      evt_data;
  logic      evt_vld;
  logic      evt_rdy;
  key_t      out_key;
  route_t    out_route;
  logic      out_vld;
  logic      out_rdy;

  // register image as software sees it, indexed by byte address
  key_t        shadow [256];
  apb_addr_t   mapped_q [$];
  key_t        exp_key_q [$];
  route_t      exp_route_q [$];
  logic        rand_rdy = 1'b0;
  logic [31:0] rdy_rnd;
  int          errors = 0;
  int          checks = 0;
  int          n_out = 0;
  int          n_drop_ref = 0;
  int          n_accepted = 0;
  int          cycles = 0;

  dvs_hssl_top u_dut (
    .pl_clk0_buf_int (pl_clk0_buf_int),
    .rst_n           (rst_n),
    .psel            (psel),
    .penable         (penable),
    .pwrite          (pwrite),
    .paddr           (paddr),
    .pwdata          (pwdata),
    .prdata          (prdata),
    .pready          (pready),
    .pslverr         (pslverr),
    .evt_data        (evt_data),
    .evt_vld         (evt_vld),
    .evt_rdy         (evt_rdy),
    .out_key         (out_key),
    .out_route       (out_route),
    .out_vld         (out_vld),
    .out_rdy         (out_rdy)
  );

  initial pl_clk0_buf_int = 1'b0;
  always #5 pl_clk0_buf_int = ~pl_clk0_buf_int;

  // ----------------------------------------------------------------------
  // reference model
  // ----------------------------------------------------------------------
  function automatic apb_addr_t reg_addr(input int base, input int idx);
    return apb_addr_t'(base + 4 * idx);
  endfunction

  // bits that a write keeps
  function automatic key_t write_mask(input apb_addr_t addr);
    if (addr == `DVS_REG_STOP) return key_t'(1);
    for (int i = 0; i < `DVS_NUM_MREGS; i++)
      if (addr == reg_addr(`DVS_REG_FSFT_BASE, i)) return key_t'((1 << `DVS_SFT_BITS) - 1);
    for (int i = 0; i < `DVS_NUM_RREGS; i++)
      if (addr == reg_addr(`DVS_REG_RT_ROUTE_BASE, i))
        return key_t'((1 << `DVS_ROUTE_BITS) - 1);
    return '1;
  endfunction

  // mapped key, then first matching table entry
  function automatic void predict(input evt_t evt, output key_t key, output route_t route,
                                  output logic drop);
    key_t k;
    key_t m;
    logic found;
    k = shadow[`DVS_REG_MP_KEY];
    for (int i = 0; i < `DVS_NUM_MREGS; i++) begin
      k = k | ((evt & shadow[reg_addr(`DVS_REG_FMSK_BASE, i)]) >>
               shadow[reg_addr(`DVS_REG_FSFT_BASE, i)][`DVS_SFT_BITS-1:0]);
    end
    found = 1'b0;
    route = '0;
    for (int i = 0; i < `DVS_NUM_RREGS; i++) begin
      m = shadow[reg_addr(`DVS_REG_RT_MASK_BASE, i)];
      if (!found && ((k & m) == (shadow[reg_addr(`DVS_REG_RT_KEY_BASE, i)] & m))) begin
        found = 1'b1;
        route = shadow[reg_addr(`DVS_REG_RT_ROUTE_BASE, i)][`DVS_ROUTE_BITS-1:0];
      end
    end
    key  = k;
    drop = !found;
  endfunction

  // ----------------------------------------------------------------------
  // checks and summary
  // ----------------------------------------------------------------------
  task automatic check_value(input string name, input key_t expected, input key_t seen);
    checks = checks + 1;
    if (expected !== seen) begin
      errors = errors + 1;
      $display("Error at %0t ns: %s expected %h, seen %h", $time, name, expected, seen);
    end
  endtask

  task automatic print_summary;
    $display("errors %0d, checks %0d, outputs %0d, reference drops %0d",
             errors, checks, n_out, n_drop_ref);
  endtask

  // ----------------------------------------------------------------------
  // apb master
  // ----------------------------------------------------------------------
  // setup, access, then idle; response sampled mid access phase
  task automatic apb_access(input logic wr, input apb_addr_t addr, input key_t wdata,
                            output key_t rdata, output logic err);
    @(posedge pl_clk0_buf_int);
    #1;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wdata;
    @(posedge pl_clk0_buf_int);
    #1;
    penable = 1'b1;
    #1;
    rdata = prdata;
    err   = pslverr;
    @(posedge pl_clk0_buf_int);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic reg_write(input apb_addr_t addr, input key_t data);
    key_t rd;
    logic err;
    apb_access(1'b1, addr, data, rd, err);
    check_value($sformatf("pslverr@%02h", addr), '0, key_t'(err));
    shadow[addr] = data & write_mask(addr);
  endtask

  task automatic reg_check(input apb_addr_t addr);
    key_t rd;
    logic err;
    apb_access(1'b0, addr, '0, rd, err);
    check_value($sformatf("pslverr@%02h", addr), '0, key_t'(err));
    check_value($sformatf("prdata@%02h", addr), shadow[addr], rd);
  endtask

  // last drop pulse lands a cycle late, so poll a while
  task automatic check_dropped(output key_t count);
    key_t rd;
    logic err;
    int   polls;
    polls = 0;
    do begin
      apb_access(1'b0, `DVS_REG_DROPPED, '0, rd, err);
      polls = polls + 1;
    end while (rd != key_t'(n_drop_ref) && polls < 20);
    check_value("prdata@a0", key_t'(n_drop_ref), rd);
    count = rd;
  endtask

  // ----------------------------------------------------------------------
  // traffic
  // ----------------------------------------------------------------------
  // random mapper, sparse table masks, catch-all in the last entry
  task automatic load_random_config;
    reg_write(`DVS_REG_STOP, '0);
    reg_write(`DVS_REG_MP_KEY, $urandom);
    for (int i = 0; i < `DVS_NUM_MREGS; i++) begin
      reg_write(reg_addr(`DVS_REG_FMSK_BASE, i), $urandom);
      reg_write(reg_addr(`DVS_REG_FSFT_BASE, i), $urandom);
    end
    for (int i = 0; i < `DVS_NUM_RREGS - 1; i++) begin
      reg_write(reg_addr(`DVS_REG_RT_KEY_BASE, i), $urandom);
      reg_write(reg_addr(`DVS_REG_RT_MASK_BASE, i), $urandom & $urandom & $urandom);
      reg_write(reg_addr(`DVS_REG_RT_ROUTE_BASE, i), $urandom);
    end
    reg_write(reg_addr(`DVS_REG_RT_KEY_BASE, `DVS_NUM_RREGS - 1), '0);
    reg_write(reg_addr(`DVS_REG_RT_MASK_BASE, `DVS_NUM_RREGS - 1), '0);
    reg_write(reg_addr(`DVS_REG_RT_ROUTE_BASE, `DVS_NUM_RREGS - 1), $urandom);
  endtask

  // event held until ready seen, expected packet queued at drive time
  task automatic send_events(input int count);
    key_t   k;
    route_t r;
    logic   drop;
    logic   taken;
    @(posedge pl_clk0_buf_int);
    #1;
    for (int n = 0; n < count; n++) begin
      evt_data = $urandom;
      evt_vld  = 1'b1;
      predict(evt_data, k, r, drop);
      if (drop) begin
        n_drop_ref = n_drop_ref + 1;
      end else begin
        exp_key_q.push_back(k);
        exp_route_q.push_back(r);
      end
      do begin
        #1;
        taken = evt_rdy;
        @(posedge pl_clk0_buf_int);
        #1;
      end while (!taken);
      n_accepted = n_accepted + 1;
    end
    evt_vld = 1'b0;
  endtask

  task automatic wait_drain;
    while (exp_key_q.size() != 0) @(posedge pl_clk0_buf_int);
  endtask

  // sink ready, random when asked
  always @(posedge pl_clk0_buf_int) begin
    #1;
    rdy_rnd = $urandom;
    out_rdy = rand_rdy ? rdy_rnd[0] : 1'b1;
  end

  // output side compared against the head of the expected queue
  always @(posedge pl_clk0_buf_int) begin
    #2;
    if (rst_n && out_vld) begin
      if (shadow[`DVS_REG_STOP][0]) begin
        errors = errors + 1;
        $display("Error at %0t ns: an output is valid while stop is set", $time);
      end
      if (out_rdy) begin
        if (exp_key_q.size() == 0) begin
          errors = errors + 1;
          $display("Error at %0t ns: output %h taken with no packet expected", $time, out_key);
        end else begin
          check_value("out_key", exp_key_q.pop_front(), out_key);
          check_value("out_route", key_t'(exp_route_q.pop_front()), key_t'(out_route));
        end
        n_out = n_out + 1;
      end
    end
  end

  // run limit
  always @(posedge pl_clk0_buf_int) begin
    cycles = cycles + 1;
    if (cycles > CYCLE_LIMIT) begin
      errors = errors + 1;
      $display("Error: the run did not end within %0d cycles", CYCLE_LIMIT);
      print_summary();
      $display("Test failed");
      $finish;
    end
  end

  // ----------------------------------------------------------------------
  // test sequence
  // ----------------------------------------------------------------------
  initial begin
    key_t rd;
    logic err;
    key_t drops;
    int   base;
    void'($urandom(SEED));
    shadow   = '{default: '0};
    rst_n    = 1'b0;
    psel     = 1'b0;
    penable  = 1'b0;
    pwrite   = 1'b0;
    paddr    = '0;
    pwdata   = '0;
    evt_data = '0;
    evt_vld  = 1'b0;
    out_rdy  = 1'b0;
    mapped_q.push_back(`DVS_REG_STOP);
    mapped_q.push_back(`DVS_REG_MP_KEY);
    for (int i = 0; i < `DVS_NUM_MREGS; i++) begin
      mapped_q.push_back(reg_addr(`DVS_REG_FMSK_BASE, i));
      mapped_q.push_back(reg_addr(`DVS_REG_FSFT_BASE, i));
    end
    for (int i = 0; i < `DVS_NUM_RREGS; i++) begin
      mapped_q.push_back(reg_addr(`DVS_REG_RT_KEY_BASE, i));
      mapped_q.push_back(reg_addr(`DVS_REG_RT_MASK_BASE, i));
      mapped_q.push_back(reg_addr(`DVS_REG_RT_ROUTE_BASE, i));
    end
    mapped_q.push_back(`DVS_REG_DROPPED);
    repeat (2) @(posedge pl_clk0_buf_int);
    #1;
    rst_n = 1'b1;

    // reset values, then write and read back
    foreach (mapped_q[m]) reg_check(mapped_q[m]);
    foreach (mapped_q[m]) if (mapped_q[m] != `DVS_REG_DROPPED) reg_write(mapped_q[m], $urandom);
    foreach (mapped_q[m]) reg_check(mapped_q[m]);

    // unmapped and read-only accesses
    foreach (BAD_ADDR[u]) begin
      apb_access(1'b1, BAD_ADDR[u], $urandom, rd, err);
      check_value($sformatf("pslverr@%02h", BAD_ADDR[u]), key_t'(1), key_t'(err));
      apb_access(1'b0, BAD_ADDR[u], '0, rd, err);
      check_value($sformatf("pslverr@%02h", BAD_ADDR[u]), key_t'(1), key_t'(err));
    end
    apb_access(1'b1, `DVS_REG_DROPPED, $urandom, rd, err);
    check_value("pslverr@a0", key_t'(1), key_t'(err));

    // random traffic with a catch-all entry
    load_random_config();
    send_events(N_MATCH_EVENTS);
    wait_drain();
    check_dropped(drops);

    // catch-all gone, unmatched keys dropped
    reg_write(reg_addr(`DVS_REG_RT_MASK_BASE, `DVS_NUM_RREGS - 1), '1);
    reg_write(reg_addr(`DVS_REG_RT_KEY_BASE, `DVS_NUM_RREGS - 1), $urandom);
    send_events(N_DROP_EVENTS);
    wait_drain();
    check_dropped(drops);

    // stop with random sink ready, released midway
    rand_rdy = 1'b1;
    reg_write(`DVS_REG_STOP, key_t'(1));
    base = n_accepted;
    fork
      send_events(N_STOP_EVENTS);
      begin
        repeat (STOP_HOLD) @(posedge pl_clk0_buf_int);
        // assembler register plus a full buffer
        check_value("accepted events while stopped", key_t'(`DVS_BUF_DEPTH + 1),
                    key_t'(n_accepted - base));
        reg_write(`DVS_REG_STOP, '0);
      end
    join
    wait_drain();
    check_dropped(drops);
    check_value("outputs plus drops", key_t'(N_EVENTS), key_t'(n_out) + drops);
    rand_rdy = 1'b0;

    print_summary();
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: files.f
+incdir+include
rtl/dvs_hssl_pkg.sv
rtl/hssl_reg_bank.sv
rtl/pkt_assembler.sv
rtl/pkt_buffer.sv
rtl/pkt_router.sv
rtl/dvs_hssl_top.sv
dv/dvs_hssl_props.sv
dv/dvs_hssl_tb.sv

// File: include/dvs_hssl_consts.svh
// sizes and register map of the sensor event to packet path
`ifndef DVS_HSSL_CONSTS_SVH
`define DVS_HSSL_CONSTS_SVH

// ----------------------------------------------------------------------
// widths
// ----------------------------------------------------------------------
// key and raw event share one width
`define DVS_KEY_BITS   32
`define DVS_ROUTE_BITS 3
`define DVS_SFT_BITS   5
`define DVS_ADDR_BITS  8

// ----------------------------------------------------------------------
// table and queue sizes
// ----------------------------------------------------------------------
`define DVS_NUM_MREGS  4
`define DVS_NUM_RREGS  8
`define DVS_BUF_DEPTH  4

// ----------------------------------------------------------------------
// register map, byte offsets, word stride 4
// ----------------------------------------------------------------------
`define DVS_REG_STOP          8'h00
`define DVS_REG_MP_KEY        8'h04
`define DVS_REG_FMSK_BASE     8'h10
`define DVS_REG_FSFT_BASE     8'h20
`define DVS_REG_RT_KEY_BASE   8'h40
`define DVS_REG_RT_MASK_BASE  8'h60
`define DVS_REG_RT_ROUTE_BASE 8'h80
// read only
`define DVS_REG_DROPPED       8'hA0

`endif

// File: rtl/dvs_hssl_pkg.sv
// shared vector types of the sensor event to packet path
`include "dvs_hssl_consts.svh"

package dvs_hssl_pkg;

  // ----------------------------------------------------------------------
  // packet and event words
  // ----------------------------------------------------------------------
  // routing key, the whole packet here
  typedef logic [`DVS_KEY_BITS-1:0]   key_t;
  // raw sensor event as it arrives
  typedef logic [`DVS_KEY_BITS-1:0]   evt_t;

  // ----------------------------------------------------------------------
  // configuration fields
  // ----------------------------------------------------------------------
  // output link number
  typedef logic [`DVS_ROUTE_BITS-1:0] route_t;
  // right shift of one mapper field
  typedef logic [`DVS_SFT_BITS-1:0]   sft_t;
  // apb byte address
  typedef logic [`DVS_ADDR_BITS-1:0]  apb_addr_t;

endpackage

// File: rtl/dvs_hssl_top.sv
// event to packet path top, register bank plus assembler, buffer and router
`timescale 1ns/100ps
`include "dvs_hssl_consts.svh"

module dvs_hssl_top (
  input  logic                    pl_clk0_buf_int,
  input  logic                    rst_n,
  input  logic                    psel,
  input  logic                    penable,
  input  logic                    pwrite,
  input  dvs_hssl_pkg::apb_addr_t paddr,
  input  dvs_hssl_pkg::key_t      pwdata,
  output dvs_hssl_pkg::key_t      prdata,
  output logic                    pready,
  output logic                    pslverr,
  input  dvs_hssl_pkg::evt_t      evt_data,
  input  logic                    evt_vld,
  output logic                    evt_rdy,
  output dvs_hssl_pkg::key_t      out_key,
  output dvs_hssl_pkg::route_t    out_route,
  output logic                    out_vld,
  input  logic                    out_rdy
);
  import dvs_hssl_pkg::*;

  // ----------------------------------------------------------------------
  // configuration from the register bank
  // ----------------------------------------------------------------------
  logic   stop;
  logic   drop_pulse;
  key_t   mp_key;
  key_t   fmsk [`DVS_NUM_MREGS];
  sft_t   fsft [`DVS_NUM_MREGS];
  key_t   rt_key [`DVS_NUM_RREGS];
  key_t   rt_mask [`DVS_NUM_RREGS];
  route_t rt_route [`DVS_NUM_RREGS];

  // assembler to buffer, buffer to router
  key_t   asm_key;
  logic   asm_vld;
  logic   asm_rdy;
  key_t   buf_key;
  logic   buf_vld;
  logic   buf_rdy;

  hssl_reg_bank u_reg_bank (
    .pl_clk0_buf_int (pl_clk0_buf_int),
    .rst_n           (rst_n),
    .psel            (psel),
    .penable         (penable),
    .pwrite          (pwrite),
    .paddr           (paddr),
    .pwdata          (pwdata),
    .prdata          (prdata),
    .pready          (pready),
    .pslverr         (pslverr),
    .drop_pulse      (drop_pulse),
    .stop            (stop),
    .mp_key          (mp_key),
    .fmsk            (fmsk),
    .fsft            (fsft),
    .rt_key          (rt_key),
    .rt_mask         (rt_mask),
    .rt_route        (rt_route)
  );

  // ----------------------------------------------------------------------
  // packet path
  // ----------------------------------------------------------------------
  pkt_assembler u_assembler (
    .pl_clk0_buf_int (pl_clk0_buf_int),
    .rst_n           (rst_n),
    .evt_data        (evt_data),
    .evt_vld         (evt_vld),
    .evt_rdy         (evt_rdy),
    .mp_key          (mp_key),
    .fmsk            (fmsk),
    .fsft            (fsft),
    .pkt_key         (asm_key),
    .pkt_vld         (asm_vld),
    .pkt_rdy         (asm_rdy)
  );

  pkt_buffer u_buffer (
    .pl_clk0_buf_int (pl_clk0_buf_int),
    .rst_n           (rst_n),
    .in_key          (asm_key),
    .in_vld          (asm_vld),
    .in_rdy          (asm_rdy),
    .out_key         (buf_key),
    .out_vld         (buf_vld),
    .out_rdy         (buf_rdy)
  );

  pkt_router u_router (
    .pl_clk0_buf_int (pl_clk0_buf_int),
    .rst_n           (rst_n),
    .in_key          (buf_key),
    .in_vld          (buf_vld),
    .in_rdy          (buf_rdy),
    .stop            (stop),
    .rt_key          (rt_key),
    .rt_mask         (rt_mask),
    .rt_route        (rt_route),
    .out_key         (out_key),
    .out_route       (out_route),
    .out_vld         (out_vld),
    .out_rdy         (out_rdy),
    .drop_pulse      (drop_pulse)
  );

endmodule

// File: rtl/hssl_reg_bank.sv
// apb register bank holding mapper, routing table, stop bit and drop count
`timescale 1ns/100ps
`include "dvs_hssl_consts.svh"

module hssl_reg_bank (
  input  logic                   pl_clk0_buf_int,
  input  logic                   rst_n,
  input  logic                   psel,
  input  logic                   penable,
  input  logic                   pwrite,
  input  dvs_hssl_pkg::apb_addr_t paddr,
  input  dvs_hssl_pkg::key_t      pwdata,
  output dvs_hssl_pkg::key_t      prdata,
  output logic                   pready,
  output logic                   pslverr,
  input  logic                   drop_pulse,
  output logic                   stop,
  output dvs_hssl_pkg::key_t      mp_key,
  output dvs_hssl_pkg::key_t      fmsk [`DVS_NUM_MREGS],
  output dvs_hssl_pkg::sft_t      fsft [`DVS_NUM_MREGS],
  output dvs_hssl_pkg::key_t      rt_key [`DVS_NUM_RREGS],
  output dvs_hssl_pkg::key_t      rt_mask [`DVS_NUM_RREGS],
  output dvs_hssl_pkg::route_t    rt_route [`DVS_NUM_RREGS]
);
  import dvs_hssl_pkg::*;

  logic                      hit_stop;
  logic                      hit_mp_key;
  logic                      hit_dropped;
  logic [`DVS_NUM_MREGS-1:0] hit_fmsk;
  logic [`DVS_NUM_MREGS-1:0] hit_fsft;
  logic [`DVS_NUM_RREGS-1:0] hit_rt_key;
  logic [`DVS_NUM_RREGS-1:0] hit_rt_mask;
  logic [`DVS_NUM_RREGS-1:0] hit_rt_route;
  logic                      mapped;
  logic                      wr_acc;
  key_t                      dropped_cnt;

  // ----------------------------------------------------------------------
  // address decode
  // ----------------------------------------------------------------------
  // exact word match only, so misaligned addresses fall out as unmapped
  always_comb begin
    hit_stop    = (paddr == `DVS_REG_STOP);
    hit_mp_key  = (paddr == `DVS_REG_MP_KEY);
    hit_dropped = (paddr == `DVS_REG_DROPPED);
    for (int i = 0; i < `DVS_NUM_MREGS; i++) begin
      hit_fmsk[i] = (paddr == apb_addr_t'(`DVS_REG_FMSK_BASE + 4 * i));
      hit_fsft[i] = (paddr == apb_addr_t'(`DVS_REG_FSFT_BASE + 4 * i));
    end
    for (int i = 0; i < `DVS_NUM_RREGS; i++) begin
      hit_rt_key[i]   = (paddr == apb_addr_t'(`DVS_REG_RT_KEY_BASE + 4 * i));
      hit_rt_mask[i]  = (paddr == apb_addr_t'(`DVS_REG_RT_MASK_BASE + 4 * i));
      hit_rt_route[i] = (paddr == apb_addr_t'(`DVS_REG_RT_ROUTE_BASE + 4 * i));
    end
  end

  assign mapped = hit_stop | hit_mp_key | hit_dropped | (|hit_fmsk) | (|hit_fsft) |
                  (|hit_rt_key) | (|hit_rt_mask) | (|hit_rt_route);

  // no wait states
  assign pready  = 1'b1;
  assign wr_acc  = psel & penable & pwrite;
  // unmapped address, or write to the read-only counter
  assign pslverr = psel & penable & (~mapped | (pwrite & hit_dropped));

  // ----------------------------------------------------------------------
  // read mux
  // ----------------------------------------------------------------------
  always_comb begin
    prdata = '0;
    if (hit_stop)    prdata = key_t'(stop);
    if (hit_mp_key)  prdata = mp_key;
    if (hit_dropped) prdata = dropped_cnt;
    for (int i = 0; i < `DVS_NUM_MREGS; i++) begin
      if (hit_fmsk[i]) prdata = fmsk[i];
      if (hit_fsft[i]) prdata = key_t'(fsft[i]);
    end
    for (int i = 0; i < `DVS_NUM_RREGS; i++) begin
      if (hit_rt_key[i])   prdata = rt_key[i];
      if (hit_rt_mask[i])  prdata = rt_mask[i];
      if (hit_rt_route[i]) prdata = key_t'(rt_route[i]);
    end
  end

  // ----------------------------------------------------------------------
  // configuration registers
  // ----------------------------------------------------------------------
  // written on the access-phase edge
  always_ff @(posedge pl_clk0_buf_int) begin
    if (!rst_n) begin
      stop   <= 1'b0;
      mp_key <= '0;
      for (int i = 0; i < `DVS_NUM_MREGS; i++) begin
        fmsk[i] <= '0;
        fsft[i] <= '0;
      end
      for (int i = 0; i < `DVS_NUM_RREGS; i++) begin
        rt_key[i]   <= '0;
        rt_mask[i]  <= '0;
        rt_route[i] <= '0;
      end
    end else if (wr_acc) begin
      if (hit_stop)   stop   <= pwdata[0];
      if (hit_mp_key) mp_key <= pwdata;
      for (int i = 0; i < `DVS_NUM_MREGS; i++) begin
        if (hit_fmsk[i]) fmsk[i] <= pwdata;
        if (hit_fsft[i]) fsft[i] <= pwdata[`DVS_SFT_BITS-1:0];
      end
      for (int i = 0; i < `DVS_NUM_RREGS; i++) begin
        if (hit_rt_key[i])   rt_key[i]   <= pwdata;
        if (hit_rt_mask[i])  rt_mask[i]  <= pwdata;
        if (hit_rt_route[i]) rt_route[i] <= pwdata[`DVS_ROUTE_BITS-1:0];
      end
    end
  end

  // dropped packets, wraps at 2^32
  always_ff @(posedge pl_clk0_buf_int) begin
    if (!rst_n) begin
      dropped_cnt <= '0;
    end else if (drop_pulse) begin
      dropped_cnt <= dropped_cnt + 1'b1;
    end
  end

endmodule

// File: rtl/pkt_assembler.sv
// event to routing key mapper with a one-entry output register
`timescale 1ns/100ps
`include "dvs_hssl_consts.svh"

module pkt_assembler (
  input  logic                pl_clk0_buf_int,
  input  logic                rst_n,
  input  dvs_hssl_pkg::evt_t  evt_data,
  input  logic                evt_vld,
  output logic                evt_rdy,
  input  dvs_hssl_pkg::key_t  mp_key,
  input  dvs_hssl_pkg::key_t  fmsk [`DVS_NUM_MREGS],
  input  dvs_hssl_pkg::sft_t  fsft [`DVS_NUM_MREGS],
  output dvs_hssl_pkg::key_t  pkt_key,
  output logic                pkt_vld,
  input  logic                pkt_rdy
);
  import dvs_hssl_pkg::*;

  key_t map_key;
  logic evt_take;

  // ----------------------------------------------------------------------
  // mapping
  // ----------------------------------------------------------------------
  // base key plus each masked field moved down into place
  always_comb begin
    map_key = mp_key;
    for (int i = 0; i < `DVS_NUM_MREGS; i++) begin
      map_key = map_key | ((evt_data & fmsk[i]) >> fsft[i]);
    end
  end

  // ----------------------------------------------------------------------
  // output register
  // ----------------------------------------------------------------------
  // free when empty or drained this cycle, one event per clock
  assign evt_rdy  = !pkt_vld || pkt_rdy;
  assign evt_take = evt_vld && evt_rdy;

  always_ff @(posedge pl_clk0_buf_int) begin
    if (!rst_n) begin
      pkt_vld <= 1'b0;
    end else if (evt_rdy) begin
      pkt_vld <= evt_vld;
    end
  end

  // key lands the cycle after acceptance
  always_ff @(posedge pl_clk0_buf_int) begin
    if (evt_take) begin
      pkt_key <= map_key;
    end
  end

endmodule

// File: rtl/pkt_buffer.sv
// circular key queue between the assembler and the router
`timescale 1ns/100ps
`include "dvs_hssl_consts.svh"

module pkt_buffer (
  input  logic               pl_clk0_buf_int,
  input  logic               rst_n,
  input  dvs_hssl_pkg::key_t in_key,
  input  logic               in_vld,
  output logic               in_rdy,
  output dvs_hssl_pkg::key_t out_key,
  output logic               out_vld,
  input  logic               out_rdy
);
  import dvs_hssl_pkg::*;

  localparam int PTR_BITS = $clog2(`DVS_BUF_DEPTH);
  localparam int CNT_BITS = $clog2(`DVS_BUF_DEPTH + 1);

  key_t                mem [`DVS_BUF_DEPTH];
  logic [PTR_BITS-1:0] wr_ptr;
  logic [PTR_BITS-1:0] rd_ptr;
  logic [CNT_BITS-1:0] count;
  logic                push;
  logic                pop;

  // ----------------------------------------------------------------------
  // handshake
  // ----------------------------------------------------------------------
  assign in_rdy  = (count != CNT_BITS'(`DVS_BUF_DEPTH));
  assign out_vld = (count != '0);
  // head entry read straight from storage
  assign out_key = mem[rd_ptr];
  assign push    = in_vld && in_rdy;
  assign pop     = out_vld && out_rdy;

  // ----------------------------------------------------------------------
  // pointers and occupancy
  // ----------------------------------------------------------------------
  always_ff @(posedge pl_clk0_buf_int) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= (wr_ptr == PTR_BITS'(`DVS_BUF_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (pop)  rd_ptr <= (rd_ptr == PTR_BITS'(`DVS_BUF_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      // simultaneous push and pop leaves count alone
      if (push && !pop)      count <= count + 1'b1;
      else if (pop && !push) count <= count - 1'b1;
    end
  end

  // storage
  always_ff @(posedge pl_clk0_buf_int) begin
    if (push) begin
      mem[wr_ptr] <= in_key;
    end
  end

endmodule

// File: rtl/pkt_router.sv
// masked key table lookup, route register, drop pulse and stop hold
`timescale 1ns/100ps
`include "dvs_hssl_consts.svh"

module pkt_router (
  input  logic                 pl_clk0_buf_int,
  input  logic                 rst_n,
  input  dvs_hssl_pkg::key_t   in_key,
  input  logic                 in_vld,
  output logic                 in_rdy,
  input  logic                 stop,
  input  dvs_hssl_pkg::key_t   rt_key [`DVS_NUM_RREGS],
  input  dvs_hssl_pkg::key_t   rt_mask [`DVS_NUM_RREGS],
  input  dvs_hssl_pkg::route_t rt_route [`DVS_NUM_RREGS],
  output dvs_hssl_pkg::key_t   out_key,
  output dvs_hssl_pkg::route_t out_route,
  output logic                 out_vld,
  input  logic                 out_rdy,
  output logic                 drop_pulse
);
  import dvs_hssl_pkg::*;

  logic   hit;
  route_t hit_route;
  logic   out_free;
  logic   take;

  // ----------------------------------------------------------------------
  // table search
  // ----------------------------------------------------------------------
  // walk down so the lowest matching entry wins
  always_comb begin
    hit       = 1'b0;
    hit_route = '0;
    for (int i = `DVS_NUM_RREGS - 1; i >= 0; i--) begin
      if ((in_key & rt_mask[i]) == (rt_key[i] & rt_mask[i])) begin
        hit       = 1'b1;
        hit_route = rt_route[i];
      end
    end
  end

  // ----------------------------------------------------------------------
  // output stage
  // ----------------------------------------------------------------------
  // stop halts intake, output already held still drains
  assign out_free = !out_vld || out_rdy;
  assign in_rdy   = !stop && out_free;
  assign take     = in_vld && in_rdy;

  always_ff @(posedge pl_clk0_buf_int) begin
    if (!rst_n) begin
      out_vld    <= 1'b0;
      drop_pulse <= 1'b0;
    end else begin
      // unmatched key consumed, counted one cycle later
      drop_pulse <= take && !hit;
      if (out_free) out_vld <= take && hit;
    end
  end

  always_ff @(posedge pl_clk0_buf_int) begin
    if (take && hit) begin
      out_key   <= in_key;
      out_route <= hit_route;
    end
  end

endmodule

// File: run.sh
#!/usr/bin/env bash
# build and run the event to packet path testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f files.f --top-module dvs_hssl_tb \
  -o dvs_hssl_sim > build.log 2>&1 || { cat build.log; echo "build FAIL"; exit 1; }

./obj_dir/dvs_hssl_sim > sim.log 2>&1
cat sim.log

grep -qx "Test passed" sim.log && echo "simulation PASS" || { echo "simulation FAIL"; exit 1; }
